// ==== logic/ddrSequencer.sv ====
module ddrSequencer
	import memBusPkg::*;
	import tileCachePkg::*;
(
	input  logic         clock,
	input  logic         reset,
	input  logic         missStart,
	input  tileEntry     victim,
	input  logic [27:0]  missTile,
	input  memResp       ddrResp,
	output memReq        ddrReq,
	output logic         fillDone,
	output logic [127:0] fillData
);

	typedef enum logic [1:0]
	{
		seqIdle,
		seqIssue,
		seqWrite,
		seqRead
	} seqState;

	seqState state;
	// dirty victim still to go out
	logic    writePending;

	logic [27:0]  victimTile;
	logic [27:0]  fetchTile;
	logic [31:0]  ddrAddr;
	logic [127:0] ddrData;
	memOpm        ddrOpm;

	assign ddrReq = '{addr: ddrAddr, data: ddrData, opm: ddrOpm};

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state        <= seqIdle;
			writePending <= 1'b0;
			ddrOpm       <= opmReady;
			fillDone     <= 1'b0;
		end
		else
		begin
			fillDone <= 1'b0;
			case (state)
				seqIdle:
				begin
					if (missStart)
					begin
						writePending <= victim.dirty;
						state        <= seqIssue;
					end
				end
				seqIssue:
				begin
					// new opm only once DDR is back to READY
					if (ddrResp.ok == okReady)
					begin
						ddrOpm <= writePending ? opmWriteTile : opmReadTile;
						state  <= writePending ? seqWrite : seqRead;
					end
				end
				seqWrite:
				begin
					// HOLD keeps opm and address as they are
					if (ddrResp.ok == okOk)
					begin
						ddrOpm       <= opmReady;
						writePending <= 1'b0;
						state        <= seqIssue;
					end
				end
				seqRead:
				begin
					if (ddrResp.ok == okOk)
					begin
						ddrOpm   <= opmReady;
						fillDone <= 1'b1;
						state    <= seqIdle;
					end
				end
				default:
				begin
					state <= seqIdle;
				end
			endcase
		end
	end

	// addresses and data
	always_ff @(posedge clock)
	begin
		if ((state == seqIdle) && missStart)
		begin
			victimTile <= victim.tile;
			fetchTile  <= missTile;
			// write data, ignored by the read
			ddrData    <= victim.data;
		end
		if ((state == seqIssue) && (ddrResp.ok == okReady))
		begin
			ddrAddr <= {writePending ? victimTile : fetchTile, 4'h0};
		end
		if ((state == seqRead) && (ddrResp.ok == okOk))
		begin
			fillData <= ddrResp.data;
		end
	end

endmodule

// ==== logic/memBusPkg.sv ====
package memBusPkg;

	// operation codes shared by the client and DDR ports
	// tile ops carry 3'b111 in the low bits
	typedef enum logic [4:0]
	{
		opmReady     = 5'b00000,
		opmFlush     = 5'b00101,
		opmWriteTile = 5'b01111,
		opmReadTile  = 5'b10111
	} memOpm;

	// answer codes from the serving side
	typedef enum logic [1:0]
	{
		okReady = 2'b00,
		okOk    = 2'b01,
		okHold  = 2'b10
	} memOk;

	// request side, 165 bits
	typedef struct packed
	{
		logic [31:0]  addr;
		logic [127:0] data;
		memOpm        opm;
	} memReq;

	// response side, 130 bits
	typedef struct packed
	{
		logic [127:0] data;
		memOk         ok;
	} memResp;

	// any tile transfer, read or write
	function automatic logic isTileOpm(memOpm opm);
		return (opm[4:3] != 2'b00) && (opm[2:0] == 3'b111);
	endfunction

endpackage

// ==== logic/tileCacheCtrl.sv ====
module tileCacheCtrl
	import memBusPkg::*;
	import tileCachePkg::*;
#(
	parameter int indexBits = tileCachePkg::indexBits
)
(
	input  logic                 clock,
	input  logic                 reset,
	input  memReq                request,
	input  tileEntry             readEntry,
	input  logic                 fillDone,
	input  logic [127:0]         fillData,
	output memResp               response,
	output logic [indexBits-1:0] readIndex,
	output storeWrite            write,
	output logic                 missStart,
	output tileEntry             victim,
	output logic [27:0]          missTile
);

	// registered client request
	tileAddr      reqAddr;
	logic [127:0] reqData;
	memOpm        reqOpm;

	logic [27:0]          reqTile;
	logic [indexBits-1:0] reqIndex;
	// index the store read last edge
	logic [indexBits-1:0] lastIndex;

	// current flush epoch, 0 only right after reset or a wrap
	logic [3:0] epoch;
	logic       flushLast;
	// request already answered with OK, a stale copy sits in the register
	logic       served;
	logic       wroteLast;
	logic       missPending;

	logic isFlush;
	logic ramAccess;
	logic settled;
	logic entryHit;
	logic hold;

	assign reqTile   = tileOf(reqAddr);
	assign reqIndex  = reqTile[indexBits-1:0];
	assign readIndex = reqIndex;

	// cached tile access inside the RAM window
	assign ramAccess = !served && isTileOpm(reqOpm) && inRamWindow(reqAddr);

	// flush is a command word on the flush opm
	assign isFlush = !served && (reqOpm == opmFlush) &&
		(reqAddr.ctrlView.region == flushRegion) &&
		(reqAddr.ctrlView.command == flushCommand);

	// store output belongs to this request and is not one write behind
	assign settled  = (lastIndex == reqIndex) && !wroteLast && (epoch != 4'h0);
	// stale epoch counts as a miss even when the tile matches
	assign entryHit = (readEntry.tile == reqTile) && (readEntry.epoch == epoch);

	assign hold = ramAccess && (!settled || !entryHit || missPending);

	// one pulse per miss, sequencer latches the victim
	assign missStart = ramAccess && settled && !entryHit && !missPending;
	assign victim    = readEntry;
	assign missTile  = reqTile;

	// client answer
	always_comb
	begin
		response.data = ramAccess ? readEntry.data : 128'h0;
		if (hold)
		begin
			response.ok = okHold;
		end
		else if (!served && (reqOpm != opmReady))
		begin
			// cached hit, uncached access or flush
			response.ok = okOk;
		end
		else
		begin
			response.ok = okReady;
		end
	end

	// store write, fill first, else write hit
	always_comb
	begin
		write             = '0;
		write.index       = storeIndexBits'(reqIndex);
		write.entry.epoch = epoch;
		write.entry.tile  = reqTile;
		if (fillDone)
		begin
			// fresh tile from DDR comes in clean
			write.enable     = 1'b1;
			write.entry.data = fillData;
		end
		else if (ramAccess && !hold && (reqOpm == opmWriteTile))
		begin
			// commits in the OK cycle
			write.enable      = 1'b1;
			write.entry.dirty = 1'b1;
			write.entry.data  = reqData;
		end
	end

	// registered opcode, READY out of reset
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			reqOpm <= opmReady;
		end
		else if (!hold)
		begin
			reqOpm <= request.opm;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			reqAddr <= request.addr;
			reqData <= request.data;
		end
		lastIndex <= reqIndex;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			epoch       <= 4'h0;
			flushLast   <= 1'b0;
			served      <= 1'b0;
			wroteLast   <= 1'b0;
			missPending <= 1'b0;
		end
		else
		begin
			// edge guard, one bump per flush
			// epoch 0 bumps itself so old lines all miss
			if ((isFlush && !flushLast) || (epoch == 4'h0))
			begin
				epoch <= epoch + 4'h1;
			end
			flushLast <= isFlush;
			served    <= (response.ok == okOk);
			wroteLast <= write.enable;
			if (fillDone)
			begin
				missPending <= 1'b0;
			end
			else if (missStart)
			begin
				missPending <= 1'b1;
			end
		end
	end

endmodule

// ==== logic/tileCachePkg.sv ====
package tileCachePkg;

	// default geometry, 256 tiles of 16 bytes
	localparam int indexBits = 8;
	// store write index is sized for any index width up to this
	localparam int storeIndexBits = 16;

	// flush command lives in the control region
	localparam logic [3:0] flushRegion  = 4'hF;
	localparam logic [3:0] flushCommand = 4'hE;

	// one request address, seen either as a tile address or as a command
	typedef union packed
	{
		struct packed
		{
			logic [27-indexBits:0] tag;
			logic [indexBits-1:0]  index;
			logic [3:0]            offset;
		} cacheView;
		struct packed
		{
			logic [3:0]  region;
			logic [23:0] ignored;
			logic [3:0]  command;
		} ctrlView;
	} tileAddr;

	// one line of the store, 161 bits
	typedef struct packed
	{
		logic [3:0]   epoch;
		logic         dirty;
		logic [27:0]  tile;
		logic [127:0] data;
	} tileEntry;

	typedef struct packed
	{
		logic                      enable;
		logic [storeIndexBits-1:0] index;
		tileEntry                  entry;
	} storeWrite;

	// full 28-bit tile number of an address
	function automatic logic [27:0] tileOf(tileAddr addr);
		return {addr.cacheView.tag, addr.cacheView.index};
	endfunction

	// RAM window: top two bits clear and some bit of 29:24 set
	function automatic logic inRamWindow(tileAddr addr);
		logic [27:0] tile;
		tile = tileOf(addr);
		return (tile[27:26] == 2'b00) && (tile[25:20] != 6'h00);
	endfunction

endpackage

// ==== logic/tileCacheTop.sv ====
module tileCacheTop
	import memBusPkg::*;
	import tileCachePkg::*;
#(
	parameter int indexBits = tileCachePkg::indexBits
)
(
	input  logic   clock,
	input  logic   reset,
	input  memReq  request,
	input  memResp ddrResp,
	output memResp response,
	output memReq  ddrReq
);

	// store read and write
	logic [indexBits-1:0] readIndex;
	tileEntry             readEntry;
	storeWrite            write;

	// miss handoff to the sequencer
	logic                 missStart;
	tileEntry             victim;
	logic [27:0]          missTile;
	logic                 fillDone;
	logic [127:0]         fillData;

	tileCacheCtrl #(
		.indexBits(indexBits)
	) ctrl (
		.clock(clock),
		.reset(reset),
		.request(request),
		.readEntry(readEntry),
		.fillDone(fillDone),
		.fillData(fillData),
		.response(response),
		.readIndex(readIndex),
		.write(write),
		.missStart(missStart),
		.victim(victim),
		.missTile(missTile)
	);

	tileStore #(
		.indexBits(indexBits)
	) store (
		.clock(clock),
		.reset(reset),
		.readIndex(readIndex),
		.write(write),
		.readEntry(readEntry)
	);

	ddrSequencer sequencer (
		.clock(clock),
		.reset(reset),
		.missStart(missStart),
		.victim(victim),
		.missTile(missTile),
		.ddrResp(ddrResp),
		.ddrReq(ddrReq),
		.fillDone(fillDone),
		.fillData(fillData)
	);

endmodule

// ==== logic/tileStore.sv ====
module tileStore
	import tileCachePkg::*;
#(
	parameter int indexBits = tileCachePkg::indexBits
)
(
	input  logic                 clock,
	input  logic                 reset,
	input  logic [indexBits-1:0] readIndex,
	input  storeWrite            write,
	output tileEntry             readEntry
);

	localparam int depth = 1 << indexBits;

	// tag, flags and data kept together per line
	tileEntry lines [0:depth-1];

	tileEntry readData;
	logic     readValid;

	// registered read port
	// a same-edge write is not seen, old line comes out
	always_ff @(posedge clock)
	begin
		readData <= lines[readIndex];
		if (write.enable)
		begin
			lines[write.index[indexBits-1:0]] <= write.entry;
		end
	end

	// first read after reset is not trusted
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			readValid <= 1'b0;
		end
		else
		begin
			readValid <= 1'b1;
		end
	end

	// epoch 0 is never a live epoch so this is always a clean miss
	always_comb
	begin
		readEntry = readData;
		if (!readValid)
		begin
			readEntry.epoch = 4'h0;
			readEntry.dirty = 1'b0;
		end
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# build the tile cache testbench with Verilator, run it, then scan the log
verilator --binary --timing --assert -Wno-fatal --top-module tileCacheTb \
	-f sim.f -o simTileCache \
	&& ./obj_dir/simTileCache +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
[ "$status" -eq 0 ] && ! grep -q "sim failed" sim.log || exit 1
exit 0

// ==== sim.f ====
logic/memBusPkg.sv
logic/tileCachePkg.sv
logic/tileStore.sv
logic/tileCacheCtrl.sv
logic/ddrSequencer.sv
logic/tileCacheTop.sv
test/tileCache_properties.sv
test/ddrModel.sv
test/tileCacheTb.sv

// ==== test/ddrModel.sv ====
module ddrModel
	import memBusPkg::*;
(
	input  logic   clock,
	input  logic   reset,
	input  memReq  ddrReq,
	output memResp ddrResp
);

	// written tiles, all others read as the fill pattern
	logic [127:0] stored [logic [27:0]];
	// finished transfers as {write, tile}, plus the data of each write
	logic [28:0]  traffic [$];
	logic [127:0] written [$];

	logic [31:0] lfsr = 32'hd14a;
	int          holdLeft;
	logic        inReset;
	memReq       seen;

	// contents before any write, every tile bit matters
	function automatic logic [127:0] fillWord(input logic [27:0] tile);
		logic [31:0] t;
		t = {4'h0, tile};
		return {~t, t * 32'h9E37_79B1, t ^ 32'hA5A5_A5A5, t};
	endfunction

	// 32-bit Galois LFSR, one shift
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		return {1'b0, state[31:1]} ^ (state[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	// one LFSR step per bit of the hold length
	task automatic drawHold(input int bits, output int length);
		int i;
		length = 0;
		for (i = 0; i < bits; i++)
		begin
			lfsr   = lfsrStep(lfsr);
			length = (length << 1) | int'(lfsr[0]);
		end
	endtask

	// finish the transfer seen at the last edge
	task automatic complete();
		logic [27:0] tile;
		tile = seen.addr[31:4];
		if (seen.opm == opmWriteTile)
		begin
			stored[tile] = seen.data;
			written.push_back(seen.data);
			ddrResp.data = '0;
		end
		else
		begin
			ddrResp.data = stored.exists(tile) ? stored[tile] : fillWord(tile);
		end
		traffic.push_back({seen.opm == opmWriteTile, tile});
		ddrResp.ok = okOk;
	endtask

	initial
	begin
		ddrResp  = '{data: '0, ok: okReady};
		holdLeft = 0;
		forever
		begin
			// request sampled at the edge, answer driven just after
			@(posedge clock);
			inReset = reset;
			seen    = ddrReq;
			#1;
			if (inReset)
			begin
				ddrResp  = '{data: '0, ok: okReady};
				holdLeft = 0;
			end
			else if (ddrResp.ok == okOk)
			begin
				ddrResp.ok = okReady;
			end
			else if (ddrResp.ok == okHold)
			begin
				if (holdLeft == 0)
				begin
					complete();
				end
				else
				begin
					holdLeft--;
				end
			end
			else if (isTileOpm(seen.opm))
			begin
				// 0 to 3 cycles of HOLD
				drawHold(2, holdLeft);
				if (holdLeft == 0)
				begin
					complete();
				end
				else
				begin
					ddrResp.ok = okHold;
					holdLeft--;
				end
			end
		end
	end

endmodule

// ==== test/tileCacheTb.sv ====
module tileCacheTb
	import memBusPkg::*;
();

	localparam int timeoutCycles = 400;

	// A and B share index 0x56, both inside the RAM window
	localparam logic [27:0] tileA = 28'h012_3456;
	localparam logic [27:0] tileB = 28'h020_0056;

	logic   clock = 1'b0;
	logic   reset;
	memReq  request;
	memResp response;
	memReq  ddrReq;
	memResp ddrResp;

	// what the client should read back, written tiles only
	logic [127:0] refWord [logic [27:0]];

	int errors;
	int testsRun;
	int testsFailed;
	int failuresBefore;
	int waited;

	tileCacheTop #(
		.indexBits(8)
	) UUT (
		.clock(clock),
		.reset(reset),
		.request(request),
		.ddrResp(ddrResp),
		.response(response),
		.ddrReq(ddrReq)
	);

	ddrModel ddr (
		.clock(clock),
		.reset(reset),
		.ddrReq(ddrReq),
		.ddrResp(ddrResp)
	);

	// client side and DDR side handshakes
	bind tileCacheCtrl handshakeChecks ctrlProps (
		.clock(clock), .reset(reset), .req(request), .resp(response));
	bind ddrSequencer handshakeChecks seqProps (
		.clock(clock), .reset(reset), .req(ddrReq), .resp(ddrResp));

	always #10 clock = ~clock;

	// untouched DDR word of a tile
	function automatic logic [127:0] backingWord(input logic [27:0] tile);
		logic [31:0] t;
		t = {4'h0, tile};
		return {~t, t * 32'h9E37_79B1, t ^ 32'hA5A5_A5A5, t};
	endfunction

	function automatic int failureCount();
		return errors + UUT.ctrl.ctrlProps.failures + UUT.sequencer.seqProps.failures;
	endfunction

	// one client transfer, called just after an edge
	task automatic access(input memOpm opm, input logic [31:0] addr,
		input logic [127:0] data, output logic [127:0] readData, output int cycles);
		request  = '{addr: addr, data: data, opm: opm};
		readData = '0;
		@(posedge clock);
		cycles = 1;
		while ((response.ok != okOk) && (cycles < timeoutCycles))
		begin
			@(posedge clock);
			cycles++;
		end
		if (response.ok == okOk)
		begin
			readData = response.data;
		end
		else
		begin
			$display("timeout at %0t: cache gave no OK for address %h", $time, addr);
			errors++;
		end
		#1;
		request.opm = opmReady;
	endtask

	task automatic checkWord(input string what, input logic [127:0] got,
		input logic [127:0] want);
		assert (got === want)
		else
		begin
			$display("Mismatch at %0t: %s gave %h, expected %h", $time, what, got, want);
			errors++;
		end
	endtask

	// DDR log against up to two expected transfers, then cleared
	task automatic checkTraffic(input string what, input int count,
		input logic [28:0] first, input logic [28:0] second);
		assert ((ddr.traffic.size() == count) &&
			((count < 1) || (ddr.traffic[0] == first)) &&
			((count < 2) || (ddr.traffic[1] == second)))
		else
		begin
			$display("Mismatch at %0t: %s, DDR log has %0d transfers, expected %0d",
				$time, what, ddr.traffic.size(), count);
			errors++;
		end
		ddr.traffic.delete();
		ddr.written.delete();
	endtask

	task automatic writeTile(input logic [27:0] tile, input logic [127:0] data);
		logic [127:0] ignored;
		access(opmWriteTile, {tile, 4'h0}, data, ignored, waited);
		refWord[tile] = data;
	endtask

	task automatic readTile(input string what, input logic [27:0] tile);
		logic [127:0] got;
		access(opmReadTile, {tile, 4'h0}, '0, got, waited);
		checkWord(what, got, refWord.exists(tile) ? refWord[tile] : backingWord(tile));
	endtask

	// flush command word, region F and code E
	task automatic flushCache();
		logic [127:0] ignored;
		access(opmFlush, 32'hF000_000E, '0, ignored, waited);
	endtask

	task automatic endTest(input string name);
		testsRun++;
		if (failureCount() == failuresBefore)
		begin
			$display("test %0d %s: ok", testsRun, name);
		end
		else
		begin
			testsFailed++;
			$display("test %0d %s: FAILED", testsRun, name);
		end
		failuresBefore = failureCount();
	endtask

	initial
	begin
		logic [127:0] ignored;
		errors         = 0;
		testsRun       = 0;
		testsFailed    = 0;
		failuresBefore = 0;
		reset          = 1'b1;
		request        = '{addr: '0, data: '0, opm: opmReady};
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;
		// idle while the first epoch comes up
		repeat (2) @(posedge clock);
		#1;

		readTile("read miss of A", tileA);
		checkTraffic("read miss of A", 1, {1'b0, tileA}, '0);
		endTest("read miss");

		writeTile(tileA, 128'h1111_2222_3333_4444_5555_6666_7777_8888);
		readTile("read after write of A", tileA);
		checkTraffic("write hit of A", 0, '0, '0);
		endTest("write hit");

		// B evicts the dirty A
		writeTile(tileA, 128'hA2A2_0001_A2A2_0002_A2A2_0003_A2A2_0004);
		readTile("read of B over dirty A", tileB);
		checkWord("writeback data of A", ddr.written[0], refWord[tileA]);
		checkTraffic("eviction of A", 2, {1'b1, tileA}, {1'b0, tileB});
		readTile("read of A after eviction", tileA);
		checkTraffic("refetch of A", 1, {1'b0, tileA}, '0);
		endTest("eviction");

		// clean A is stale after a flush
		flushCache();
		readTile("read of A after flush", tileA);
		checkTraffic("flush of clean A", 1, {1'b0, tileA}, '0);
		// dirty A still goes out after a flush
		writeTile(tileA, 128'h3C3C_5A5A_0F0F_9696_C3C3_A5A5_F0F0_6969);
		flushCache();
		readTile("read of B after flush", tileB);
		checkWord("writeback data after flush", ddr.written[0], refWord[tileA]);
		checkTraffic("flush of dirty A", 2, {1'b1, tileA}, {1'b0, tileB});
		endTest("flush");

		access(opmReadTile, 32'h0000_1230, '0, ignored, waited);
		assert (waited <= 2)
		else
		begin
			$display("uncached read was held for %0d cycles before OK", waited);
			errors++;
		end
		access(opmWriteTile, 32'hC000_0040, 128'h5, ignored, waited);
		checkTraffic("uncached accesses", 0, '0, '0);
		endTest("uncached");

		$display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
			testsRun, testsFailed, errors, failureCount() - errors);
		if (failureCount() == 0)
		begin
			$display("sim passed");
		end
		else
		begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== test/tileCache_properties.sv ====
module handshakeChecks
	import memBusPkg::*;
(
	input logic   clock,
	input logic   reset,
	input memReq  req,
	input memResp resp
);

	// count of failed assertions
	int failures = 0;

	// requester keeps the whole request while held off
	holdStable: assert property (@(posedge clock) disable iff (reset)
		(resp.ok == okHold) |=> $stable(req))
	else
	begin
		$error("request changed while the response was HOLD");
		failures++;
	end

	// OK only answers a real operation
	okNeedsOp: assert property (@(posedge clock) disable iff (reset)
		(resp.ok == okOk) |-> (req.opm != opmReady))
	else
	begin
		$error("OK given while the request opm was READY");
		failures++;
	end

	// a new opm leaves READY only after okReady was seen
	issueAfterReady: assert property (@(posedge clock) disable iff (reset)
		((req.opm != opmReady) && ($past(req.opm) == opmReady)) |->
		($past(resp.ok) == okReady))
	else
	begin
		$error("new operation issued before the response was READY");
		failures++;
	end

	// both sides idle right after a reset edge
	readyAfterReset: assert property (@(posedge clock)
		reset |=> (resp.ok == okReady) && (req.opm == opmReady))
	else
	begin
		$error("port not READY after reset");
		failures++;
	end

endmodule
